//--- gpuParserPkg.sv
// GPU command parser shared types
// Command classes, parse states, issue codes, strobe bundles and command-byte constants

package gpuParserPkg;

    // ------------------------------
    // Command byte layout
    // ------------------------------
    localparam int CMD_BYTE_LSB = 24;

    localparam logic [7:0] CMD_BYTE_NOP          = 8'h00;
    localparam logic [7:0] CMD_BYTE_FILL         = 8'h02;
    localparam logic [7:0] CMD_BYTE_ATTRIB_FIRST = 8'hE1;
    localparam logic [7:0] CMD_BYTE_ATTRIB_LAST  = 8'hE6;
    // Top three bits of the byte select polygon and line groups
    localparam logic [2:0] CMD_GROUP_POLY = 3'b001;
    localparam logic [2:0] CMD_GROUP_LINE = 3'b010;

    // Polyline end marker, 5xxx5xxx
    localparam logic [31:0] TERMINATOR_MASK  = 32'hF000_F000;
    localparam logic [31:0] TERMINATOR_VALUE = 32'h5000_5000;

    // Attribute slots, low bits of E1..E6
    localparam logic [2:0] ATTRIB_TEX_PAGE    = 3'd1;
    localparam logic [2:0] ATTRIB_TEX_WINDOW  = 3'd2;
    localparam logic [2:0] ATTRIB_DRAW_TL     = 3'd3;
    localparam logic [2:0] ATTRIB_DRAW_BR     = 3'd4;
    localparam logic [2:0] ATTRIB_DRAW_OFFSET = 3'd5;
    localparam logic [2:0] ATTRIB_MASK        = 3'd6;

    // ------------------------------
    // Types
    // ------------------------------
    typedef enum logic [2:0] {
        CMD_NOP, CMD_ATTRIB, CMD_POLY, CMD_LINE, CMD_FILL, CMD_OTHER
    } cmdKind_t;

    typedef struct packed {
        cmdKind_t   kind;
        logic       isQuad;
        logic       perVertexColor;
        logic       isPolyline;
        logic [2:0] attribIndex;
    } cmdInfo_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_COMMAND, ST_COLOR, ST_VERTEX, ST_XY, ST_SIZE,
        ST_WAIT_DONE, ST_COLOR_HOLD, ST_VERTEX_HOLD
    } parserState_t;

    typedef enum logic [1:0] {
        ISSUE_NONE, ISSUE_TRIANGLE, ISSUE_LINE, ISSUE_FILL
    } primIssue_t;

    // Vertex register strobes, vertexId 3 selects no slot
    typedef struct packed {
        logic       loadVertex;
        logic       loadColor;
        logic       loadAllColor;
        logic       loadCorner;
        logic       loadSize;
        logic [1:0] vertexId;
    } vertexCtl_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] index;
    } attribLoad_t;

    typedef struct packed {
        logic [23:0] texPage;
        logic [23:0] texWindow;
        logic [23:0] drawAreaTL;
        logic [23:0] drawAreaBR;
        logic [23:0] drawOffset;
        logic [23:0] maskSetting;
    } attribRegs_t;

endpackage

//--- gpuCommandDecoder.sv
// GPU command decoder
// Turns a command byte into its class and the per-command flags

`timescale 1ns/1ps

module gpuCommandDecoder (
    input  logic [7:0]             i_command,
    output gpuParserPkg::cmdInfo_t o_info
);
    import gpuParserPkg::*;

    cmdKind_t kind;
    logic     isPolyOrLine;

    // Byte range to class
    always_comb begin
        if (i_command == CMD_BYTE_NOP) begin
            kind = CMD_NOP;
        end else if (i_command == CMD_BYTE_FILL) begin
            kind = CMD_FILL;
        end else if (i_command[7:5] == CMD_GROUP_POLY) begin
            kind = CMD_POLY;
        end else if (i_command[7:5] == CMD_GROUP_LINE) begin
            kind = CMD_LINE;
        end else if ((i_command >= CMD_BYTE_ATTRIB_FIRST) &&
                     (i_command <= CMD_BYTE_ATTRIB_LAST)) begin
            kind = CMD_ATTRIB;
        end else begin
            // E0, E7.., copies, sprites and the rest
            kind = CMD_OTHER;
        end
    end

    assign isPolyOrLine = (kind == CMD_POLY) || (kind == CMD_LINE);

    // Word bit 27 is byte bit 3, word bit 28 is byte bit 4
    always_comb begin
        o_info.kind           = kind;
        o_info.isQuad         = (kind == CMD_POLY) & i_command[3];
        o_info.perVertexColor = isPolyOrLine & i_command[4];
        o_info.isPolyline     = (kind == CMD_LINE) & i_command[3];
        o_info.attribIndex    = i_command[2:0];
    end

endmodule

//--- gpuVertexCounter.sv
// Vertex counter
// Tracks loaded vertices and derives the slot and primitive-emit conditions

`timescale 1ns/1ps

module gpuVertexCounter (
    input  logic                   i_clk,
    input  logic                   i_rstGPU,
    input  logic                   i_clear,
    input  logic                   i_increment,
    input  gpuParserPkg::cmdInfo_t i_info,
    output logic [1:0]             o_vertexId,
    output logic                   o_isSecondVertex,
    output logic                   o_canEmitTriangle,
    output logic                   o_isFinalPolyVertex
);
    import gpuParserPkg::*;

    logic [1:0] vertexCnt;
    // Polylines keep cycling, so a zero count does not mean first
    logic       isFirstVertex;

    always_ff @(posedge i_clk) begin
        if (i_rstGPU || i_clear) begin
            vertexCnt     <= 2'd0;
            isFirstVertex <= 1'b1;
        end else if (i_increment) begin
            vertexCnt     <= vertexCnt + 2'd1;
            isFirstVertex <= 1'b0;
        end
    end

    // Lines ping-pong 0/1, quad vertex 4 lands in slot 0
    always_comb begin
        if (i_info.kind == CMD_LINE) begin
            o_vertexId = {1'b0, vertexCnt[0]};
        end else if (i_info.kind == CMD_POLY) begin
            o_vertexId = (vertexCnt == 2'd3) ? 2'd0 : vertexCnt;
        end else begin
            o_vertexId = 2'd3;
        end
    end

    assign o_isSecondVertex    = i_info.isPolyline ? !isFirstVertex : (vertexCnt == 2'd1);
    assign o_canEmitTriangle   = vertexCnt[1];
    assign o_isFinalPolyVertex = i_info.isQuad ? (vertexCnt == 2'd3) : (vertexCnt == 2'd2);

endmodule

//--- gpuParserFsm.sv
// Parse state machine
// Stores the command byte, steps through parameter words, drives reads, strobes and issue

`timescale 1ns/1ps

module gpuParserFsm (
    input  logic                      i_clk,
    input  logic                      i_rstGPU,
    input  logic [31:0]               i_fifoData,
    input  logic                      i_dataValid,
    input  logic                      i_isTerminator,
    input  logic                      i_isFifoNotEmpty,
    input  logic                      i_gpuBusy,
    input  logic                      i_ignoreColor,
    input  gpuParserPkg::cmdInfo_t    i_info,
    input  logic [1:0]                i_vertexId,
    input  logic                      i_isSecondVertex,
    input  logic                      i_canEmitTriangle,
    input  logic                      i_isFinalPolyVertex,
    output logic [7:0]                o_command,
    output logic                      o_clearVertex,
    output logic                      o_incVertex,
    output logic                      o_readFIFO,
    output gpuParserPkg::vertexCtl_t  o_vertexCtl,
    output gpuParserPkg::attribLoad_t o_attribLoad,
    output gpuParserPkg::primIssue_t  o_issuePrimitive,
    output logic                      o_waitingNewCommand
);
    import gpuParserPkg::*;

    parserState_t stateQ;
    parserState_t nextLogical;
    parserState_t nextState;
    logic [7:0]   commandQ;
    logic         needWord;
    logic         cmdDone;
    primIssue_t   issue;
    vertexCtl_t   ctl;

    // ------------------------------
    // Command byte and state
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rstGPU) begin
            stateQ   <= ST_IDLE;
            commandQ <= 8'd0;
        end else begin
            stateQ <= nextState;
            if (stateQ == ST_COMMAND && i_dataValid) begin
                commandQ <= o_command;
            end
        end
    end

    // Decoder sees the live byte while it is being captured
    assign o_command = (stateQ == ST_COMMAND) ? i_fifoData[CMD_BYTE_LSB +: 8] : commandQ;

    // Attribute write lands one clock after the command word
    always_ff @(posedge i_clk) begin
        if (i_rstGPU) begin
            o_attribLoad <= '0;
        end else begin
            o_attribLoad.valid <= (stateQ == ST_COMMAND) && i_dataValid &&
                                  (i_info.kind == CMD_ATTRIB);
            o_attribLoad.index <= i_info.attribIndex;
        end
    end

    // ------------------------------
    // Next state and strobes
    // ------------------------------
    always_comb begin
        nextLogical   = stateQ;
        needWord      = 1'b0;
        cmdDone       = 1'b0;
        issue         = ISSUE_NONE;
        ctl           = '0;
        ctl.vertexId  = 2'd3;
        o_clearVertex = 1'b0;
        o_incVertex   = 1'b0;
        case (stateQ)
            ST_IDLE: begin
                o_clearVertex = 1'b1;
                needWord      = 1'b1;
                nextLogical   = ST_COMMAND;
            end
            ST_COMMAND: if (i_dataValid) begin
                // First color rides in the command word
                ctl.loadColor    = 1'b1;
                ctl.loadAllColor = i_ignoreColor | ~i_info.perVertexColor;
                ctl.vertexId     = i_vertexId;
                case (i_info.kind)
                    CMD_POLY, CMD_LINE: begin
                        needWord    = 1'b1;
                        nextLogical = ST_VERTEX;
                    end
                    CMD_FILL: begin
                        needWord    = 1'b1;
                        nextLogical = ST_XY;
                    end
                    default: nextLogical = ST_IDLE;
                endcase
            end
            ST_XY: if (i_dataValid) begin
                ctl.loadCorner = 1'b1;
                needWord       = 1'b1;
                nextLogical    = ST_SIZE;
            end
            ST_SIZE: if (i_dataValid) begin
                ctl.loadSize = 1'b1;
                issue        = ISSUE_FILL;
                nextLogical  = ST_WAIT_DONE;
            end
            ST_COLOR: if (i_dataValid) begin
                // Terminator may replace a color
                if (i_info.isPolyline && i_isTerminator) begin
                    nextLogical = ST_IDLE;
                end else begin
                    ctl.loadColor = 1'b1;
                    ctl.vertexId  = i_vertexId;
                    needWord      = 1'b1;
                    nextLogical   = ST_VERTEX;
                end
            end
            ST_VERTEX: if (i_dataValid) begin
                if (i_info.isPolyline && i_isTerminator) begin
                    nextLogical = ST_IDLE;
                end else begin
                    ctl.loadVertex = 1'b1;
                    ctl.vertexId   = i_vertexId;
                    o_incVertex    = 1'b1;
                    if (i_info.kind == CMD_POLY) begin
                        if (i_canEmitTriangle) begin
                            issue = ISSUE_TRIANGLE;
                        end
                        cmdDone = i_isFinalPolyVertex;
                    end else begin
                        if (i_isSecondVertex) begin
                            issue = ISSUE_LINE;
                        end
                        cmdDone = i_isSecondVertex & ~i_info.isPolyline;
                    end
                    if (cmdDone) begin
                        nextLogical = ST_WAIT_DONE;
                    end else if (issue != ISSUE_NONE) begin
                        // Park until the renderer has taken the vertices
                        nextLogical = i_info.perVertexColor ? ST_COLOR_HOLD : ST_VERTEX_HOLD;
                    end else begin
                        needWord    = 1'b1;
                        nextLogical = i_info.perVertexColor ? ST_COLOR : ST_VERTEX;
                    end
                end
            end
            // Read is blocked by busy, so these exit once rendering ends
            ST_COLOR_HOLD: begin
                needWord    = 1'b1;
                nextLogical = ST_COLOR;
            end
            ST_VERTEX_HOLD: begin
                needWord    = 1'b1;
                nextLogical = ST_VERTEX;
            end
            ST_WAIT_DONE: nextLogical = i_gpuBusy ? ST_WAIT_DONE : ST_IDLE;
            default: nextLogical = ST_IDLE;
        endcase
    end

    // Word-consuming transitions only advance on a read
    assign o_readFIFO          = needWord & i_isFifoNotEmpty & ~i_gpuBusy;
    assign nextState           = (!needWord || o_readFIFO) ? nextLogical : stateQ;
    assign o_vertexCtl         = ctl;
    assign o_issuePrimitive    = i_gpuBusy ? ISSUE_NONE : issue;
    assign o_waitingNewCommand = (stateQ == ST_IDLE);

    // A request raised while the renderer is busy would be masked and lost
    assert property (@(posedge i_clk) disable iff (i_rstGPU)
        i_gpuBusy |-> (issue == ISSUE_NONE))
        else $error("primitive request dropped while renderer busy");

    // Renderer answers a request with busy, so the next cycle cannot read
    assert property (@(posedge i_clk) disable iff (i_rstGPU)
        (o_issuePrimitive != ISSUE_NONE) |=> !o_readFIFO)
        else $error("FIFO read right after primitive issue");

endmodule

//--- gpuAttribRegs.sv
// Render attribute registers
// Latches the 24-bit payloads of E1..E6 by decoded index

`timescale 1ns/1ps

module gpuAttribRegs (
    input  logic                      i_clk,
    input  logic                      i_rstGPU,
    input  gpuParserPkg::attribLoad_t i_attribLoad,
    input  logic [23:0]               i_payload,
    output gpuParserPkg::attribRegs_t o_regs
);
    import gpuParserPkg::*;

    // Command word payload, one cycle behind the FIFO
    logic [23:0] payloadQ;

    always_ff @(posedge i_clk) begin
        payloadQ <= i_payload;
    end

    // ------------------------------
    // Indexed write
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rstGPU) begin
            o_regs <= '0;
        end else if (i_attribLoad.valid) begin
            case (i_attribLoad.index)
                ATTRIB_TEX_PAGE:    o_regs.texPage     <= payloadQ;
                ATTRIB_TEX_WINDOW:  o_regs.texWindow   <= payloadQ;
                ATTRIB_DRAW_TL:     o_regs.drawAreaTL  <= payloadQ;
                ATTRIB_DRAW_BR:     o_regs.drawAreaBR  <= payloadQ;
                ATTRIB_DRAW_OFFSET: o_regs.drawOffset  <= payloadQ;
                ATTRIB_MASK:        o_regs.maskSetting <= payloadQ;
                // E0 and E7 never get here
                default: ;
            endcase
        end
    end

endmodule

//--- gpuParser.sv
// GPU command parser top level
// Finds the polyline terminator and connects decoder, counter, FSM and registers

`timescale 1ns/1ps

module gpuParser (
    input  logic                      i_clk,
    input  logic                      i_rstGPU,
    input  logic [31:0]               i_fifoData,
    input  logic                      i_dataValid,
    input  logic                      i_isFifoNotEmpty,
    input  logic                      i_gpuBusy,
    input  logic                      i_ignoreColor,
    output logic                      o_readFIFO,
    output gpuParserPkg::primIssue_t  o_issuePrimitive,
    output gpuParserPkg::vertexCtl_t  o_vertexCtl,
    output gpuParserPkg::attribRegs_t o_attribRegs,
    output logic                      o_waitingNewCommand
);
    import gpuParserPkg::*;

    cmdInfo_t    info;
    attribLoad_t attribLoad;
    logic [7:0]  command;
    logic [1:0]  vertexId;
    logic        isTerminator;
    logic        clearVertex;
    logic        incVertex;
    logic        isSecondVertex;
    logic        canEmitTriangle;
    logic        isFinalPolyVertex;

    // Only meaningful on a valid word inside a polyline
    assign isTerminator = ((i_fifoData & TERMINATOR_MASK) == TERMINATOR_VALUE);

    gpuCommandDecoder u_decoder (
        .i_command (command),
        .o_info    (info)
    );

    gpuVertexCounter u_vertexCounter (
        .i_clk               (i_clk),
        .i_rstGPU            (i_rstGPU),
        .i_clear             (clearVertex),
        .i_increment         (incVertex),
        .i_info              (info),
        .o_vertexId          (vertexId),
        .o_isSecondVertex    (isSecondVertex),
        .o_canEmitTriangle   (canEmitTriangle),
        .o_isFinalPolyVertex (isFinalPolyVertex)
    );

    gpuParserFsm u_fsm (
        .i_clk               (i_clk),
        .i_rstGPU            (i_rstGPU),
        .i_fifoData          (i_fifoData),
        .i_dataValid         (i_dataValid),
        .i_isTerminator      (isTerminator),
        .i_isFifoNotEmpty    (i_isFifoNotEmpty),
        .i_gpuBusy           (i_gpuBusy),
        .i_ignoreColor       (i_ignoreColor),
        .i_info              (info),
        .i_vertexId          (vertexId),
        .i_isSecondVertex    (isSecondVertex),
        .i_canEmitTriangle   (canEmitTriangle),
        .i_isFinalPolyVertex (isFinalPolyVertex),
        .o_command           (command),
        .o_clearVertex       (clearVertex),
        .o_incVertex         (incVertex),
        .o_readFIFO          (o_readFIFO),
        .o_vertexCtl         (o_vertexCtl),
        .o_attribLoad        (attribLoad),
        .o_issuePrimitive    (o_issuePrimitive),
        .o_waitingNewCommand (o_waitingNewCommand)
    );

    // Payload is the low part of the command word
    gpuAttribRegs u_attribRegs (
        .i_clk        (i_clk),
        .i_rstGPU     (i_rstGPU),
        .i_attribLoad (attribLoad),
        .i_payload    (i_fifoData[CMD_BYTE_LSB-1:0]),
        .o_regs       (o_attribRegs)
    );

endmodule

//--- tb_gpuParser.sv
// Testbench for the GPU command parser
// File-driven command words through a FIFO model, random render busy, count and register checks

`timescale 1ns/1ps

module tb_gpuParser;
    import gpuParserPkg::*;

    logic        i_clk = 1'b0;
    logic        i_rstGPU;
    logic [31:0] i_fifoData;
    logic        i_dataValid;
    logic        i_isFifoNotEmpty;
    logic        i_gpuBusy;
    logic        i_ignoreColor;
    logic        o_readFIFO;
    primIssue_t  o_issuePrimitive;
    vertexCtl_t  o_vertexCtl;
    attribRegs_t o_attribRegs;
    logic        o_waitingNewCommand;

    // FIFO and renderer models
    logic [31:0] fifoQ[$];
    logic        readSeen = 1'b0;
    logic        issueSeen = 1'b0;
    int unsigned busyLeft = 0;
    logic [31:0] rngState = 32'h3184;

    // Per-test observations
    int          triCount = 0;
    int          lineCount = 0;
    int          fillCount = 0;
    int          cornerCount = 0;
    int          sizeCount = 0;
    logic        allColorSeen = 1'b0;
    logic        firstAllColor = 1'b0;
    int          idleRun = 0;

    // Run bookkeeping
    int          cycleCount = 0;
    int          cycleLimit = 100;
    int          fd;
    string       testName;
    logic [8*256-1:0] lineBuf;
    int          testCount = 0;
    int          failedTests = 0;
    int          mismatchTotal = 0;
    logic        badFile = 1'b0;

    gpuParser u_dut (
        .i_clk               (i_clk),
        .i_rstGPU            (i_rstGPU),
        .i_fifoData          (i_fifoData),
        .i_dataValid         (i_dataValid),
        .i_isFifoNotEmpty    (i_isFifoNotEmpty),
        .i_gpuBusy           (i_gpuBusy),
        .i_ignoreColor       (i_ignoreColor),
        .o_readFIFO          (o_readFIFO),
        .o_issuePrimitive    (o_issuePrimitive),
        .o_vertexCtl         (o_vertexCtl),
        .o_attribRegs        (o_attribRegs),
        .o_waitingNewCommand (o_waitingNewCommand)
    );

    // 8 ns period
    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycleCount = cycleCount + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // E1..E6 map onto the register fields in order
    function automatic logic [23:0] attribField(input attribRegs_t regs, input int idx);
        case (idx)
            1: return regs.texPage;
            2: return regs.texWindow;
            3: return regs.drawAreaTL;
            4: return regs.drawAreaBR;
            5: return regs.drawOffset;
            6: return regs.maskSetting;
            default: return 24'h0;
        endcase
    endfunction

    task automatic checkValue(input string sigName, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: got 0x%h, expected 0x%h", testName, sigName, actual, expected);
            mismatchTotal = mismatchTotal + 1;
        end
    endtask

    // ------------------------------
    // Models
    // ------------------------------
    // Outputs sampled mid-cycle where they are settled
    always @(negedge i_clk) begin
        readSeen  = o_readFIFO;
        issueSeen = (o_issuePrimitive != ISSUE_NONE);
        case (o_issuePrimitive)
            ISSUE_TRIANGLE: triCount = triCount + 1;
            ISSUE_LINE:     lineCount = lineCount + 1;
            ISSUE_FILL:     fillCount = fillCount + 1;
            default: ;
        endcase
        // Fill strobes for the top-left and size words
        if (o_vertexCtl.loadCorner) begin
            cornerCount = cornerCount + 1;
        end
        if (o_vertexCtl.loadSize) begin
            sizeCount = sizeCount + 1;
        end
        // First color strobe of a test belongs to its command word
        if (o_vertexCtl.loadColor && !allColorSeen) begin
            allColorSeen  = 1'b1;
            firstAllColor = o_vertexCtl.loadAllColor;
        end
        if (o_waitingNewCommand && !i_isFifoNotEmpty && !i_dataValid && !i_gpuBusy) begin
            idleRun = idleRun + 1;
        end else begin
            idleRun = 0;
        end
    end

    // Data one cycle after each read, busy on the cycle after each request
    always @(posedge i_clk) begin
        #1;
        if (readSeen && fifoQ.size() != 0) begin
            i_fifoData  = fifoQ.pop_front();
            i_dataValid = 1'b1;
        end else begin
            i_dataValid = 1'b0;
        end
        i_isFifoNotEmpty = (fifoQ.size() != 0);
        if (issueSeen) begin
            rngState  = xorshift(rngState);
            busyLeft  = (rngState % 6) + 1;
            i_gpuBusy = 1'b1;
        end else if (busyLeft > 0) begin
            busyLeft  = busyLeft - 1;
            i_gpuBusy = (busyLeft != 0);
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    task automatic runTest();
        int          ignoreFlag;
        int          wordCount;
        int          expTri;
        int          expLine;
        int          expFill;
        int          expAll;
        int          attribIdx;
        int          got;
        int          mismatchesBefore;
        logic [31:0] expReg;
        logic [31:0] words [0:15];
        testCount = testCount + 1;
        got = $fscanf(fd, "%d %d", ignoreFlag, wordCount);
        if (got != 2 || wordCount < 1 || wordCount > 16) begin
            $display("%s: word count missing or outside 1 to 16", testName);
            failedTests = failedTests + 1;
            return;
        end
        got = 0;
        for (int i = 0; i < wordCount; i++) begin
            got = got + $fscanf(fd, "%h", words[i]);
        end
        got = got + $fscanf(fd, "%d %d %d %d %d %h", expTri, expLine, expFill, expAll,
                            attribIdx, expReg);
        if (got != wordCount + 6) begin
            $display("%s: line in the stimulus file is incomplete", testName);
            failedTests = failedTests + 1;
            return;
        end
        cycleLimit = cycleLimit + 200;
        @(posedge i_clk);
        #1;
        i_ignoreColor = ignoreFlag[0];
        triCount      = 0;
        lineCount     = 0;
        fillCount     = 0;
        cornerCount   = 0;
        sizeCount     = 0;
        allColorSeen  = 1'b0;
        @(negedge i_clk);
        for (int i = 0; i < wordCount; i++) begin
            fifoQ.push_back(words[i]);
        end
        // Let the monitor see the filled FIFO before looking for idle
        @(posedge i_clk);
        @(posedge i_clk);
        while (idleRun < 3) begin
            @(posedge i_clk);
        end
        #2;
        mismatchesBefore = mismatchTotal;
        checkValue("ISSUE_TRIANGLE count", triCount, expTri);
        checkValue("ISSUE_LINE count", lineCount, expLine);
        checkValue("ISSUE_FILL count", fillCount, expFill);
        // Each fill reads one top-left word and one size word
        checkValue("o_vertexCtl.loadCorner count", cornerCount, expFill);
        checkValue("o_vertexCtl.loadSize count", sizeCount, expFill);
        if (!allColorSeen) begin
            $display("%s: no color strobe was seen at the command word", testName);
            mismatchTotal = mismatchTotal + 1;
        end else begin
            checkValue("o_vertexCtl.loadAllColor", firstAllColor, expAll);
        end
        if (attribIdx != 0) begin
            checkValue($sformatf("o_attribRegs[E%0d]", attribIdx),
                       {8'h00, attribField(o_attribRegs, attribIdx)}, expReg);
        end
        if (mismatchTotal == mismatchesBefore) begin
            $display("%s ok", testName);
        end else begin
            $display("%s: %0d mismatches", testName, mismatchTotal - mismatchesBefore);
            failedTests = failedTests + 1;
        end
    endtask

    initial begin
        i_rstGPU         = 1'b1;
        i_fifoData       = 32'h0;
        i_dataValid      = 1'b0;
        i_isFifoNotEmpty = 1'b0;
        i_gpuBusy        = 1'b0;
        i_ignoreColor    = 1'b0;
        fd = $fopen("gpuParserTests.txt", "r");
        repeat (2) @(posedge i_clk);
        #1;
        i_rstGPU = 1'b0;
        if (fd == 0) begin
            $display("cannot open gpuParserTests.txt for reading");
            badFile = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                if ($fscanf(fd, "%s", testName) == 1) begin
                    // Lines opening with # describe the columns
                    if (testName[0] == "#") begin
                        void'($fgets(lineBuf, fd));
                    end else begin
                        runTest();
                    end
                end
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d with errors, %0d value mismatches",
                 testCount, failedTests, mismatchTotal);
        if (!badFile && failedTests == 0 && testCount > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog, limit grows by 200 cycles per test read
    initial begin
        while (cycleCount < cycleLimit) begin
            @(negedge i_clk);
        end
        $display("timeout: parser did not return to idle after %0d cycles", cycleCount);
        $display("test failed");
        $finish;
    end

endmodule

//--- gpuParserTests.txt
# name ignoreColor wordCount words... triangles lines fills loadAllColor attribIndex attribValue
# words and attribValue in hex, other fields decimal, attribIndex 0 skips the register check
attrTexPage 0 1 E1000123 0 0 0 1 1 000123
attrTexWindow 0 1 E2ABCDEF 0 0 0 1 2 ABCDEF
attrDrawTL 0 1 E3012345 0 0 0 1 3 012345
attrDrawBR 0 1 E4054321 0 0 0 1 4 054321
attrDrawOffset 0 1 E5123456 0 0 0 1 5 123456
attrMask 0 1 E6000003 0 0 0 1 6 000003
flatTri 0 4 20FF0000 00100010 00200050 00500020 1 0 0 1 0 0
flatQuad 0 5 2800FF00 00100010 00100080 00800010 00800080 2 0 0 1 0 0
gouraudTri 0 6 300000FF 00100010 0000FF00 00200050 00FF0000 00500020 1 0 0 0 0 0
gouraudQuad 0 8 380000FF 00100010 0000FF00 00100080 00FF0000 00800010 00FFFFFF 00800080 2 0 0 0 0 0
gouraudOverride 1 6 300000FF 00100010 0000FF00 00200050 00FF0000 00500020 1 0 0 1 0 0
line 0 3 40FFFFFF 00100010 00800080 0 1 0 1 0 0
gouraudLine 0 4 50FF0000 00100010 000000FF 00800080 0 1 0 0 0 0
polyline 0 6 48FFFFFF 00100010 00800010 00800080 00100080 55555555 0 3 0 1 0 0
gouraudPolyline 0 7 58FF0000 00100010 0000FF00 00800010 000000FF 00800080 50005000 0 2 0 0 0 0
polylineOverride 1 7 58FF0000 00100010 0000FF00 00800010 000000FF 00800080 5FFF5FFF 0 2 0 1 0 0
fill 0 3 02123456 00100020 00400030 0 0 1 1 0 0
nopAndUnknown 0 5 00000000 01000000 E0111111 E7222222 80000000 0 0 0 1 1 000123
mixed 0 8 E3000777 20FF0000 00100010 00200050 00500020 40FFFFFF 00100010 00800080 1 1 0 1 3 000777

//--- vlog.f
gpuParserPkg.sv
gpuCommandDecoder.sv
gpuVertexCounter.sv
gpuParserFsm.sv
gpuAttribRegs.sv
gpuParser.sv
tb_gpuParser.sv
